/* common/oflow_pkg.sv */
// shared widths and types for the history buffer
// sizes are fixed: 8 slots, 16 bboxes per frame, 32 bit words
package oflow_pkg;

	// --------------------------------------------------
	// sizes
	// --------------------------------------------------
	// one feature word
	localparam int DATA_WIDTH = 32;
	// bbox pairs per frame slot
	localparam int MAX_BBOX = 16;
	// frame slots in the ring, usable history is HIST_SLOTS-1
	localparam int HIST_SLOTS = 8;
	// credits held by the reader out of reset
	localparam int CREDIT_MAX = 4;

	// derived widths
	localparam int SLOT_W = $clog2(HIST_SLOTS);
	localparam int OFFSET_W = $clog2(MAX_BBOX);
	localparam int ADDR_W = SLOT_W + OFFSET_W;
	localparam int MEM_DEPTH = HIST_SLOTS * MAX_BBOX;

	// --------------------------------------------------
	// vector types
	// --------------------------------------------------
	typedef logic [DATA_WIDTH-1:0] data_t;
	// serial frame number 0-255, doubles as slot tag
	typedef logic [7:0] frame_num_t;
	// ring slot = frame number mod HIST_SLOTS
	typedef logic [SLOT_W-1:0] slot_t;
	// bbox index inside a slot
	typedef logic [OFFSET_W-1:0] offset_t;
	// memory address, slot in the upper bits
	typedef logic [ADDR_W-1:0] addr_t;
	// bboxes in a frame, 0-16
	typedef logic [OFFSET_W:0] bbox_cnt_t;
	// history depth or frame age 1-7
	typedef logic [2:0] hist_cnt_t;
	// credit counter 0-4
	typedef logic [2:0] credit_cnt_t;

	// --------------------------------------------------
	// reader fsm
	// --------------------------------------------------
	typedef enum logic [1:0] {
		RD_IDLE   = 2'd0,
		RD_SELECT = 2'd1,
		RD_ISSUE  = 2'd2,
		RD_DRAIN  = 2'd3
	} rd_state_t;

endpackage

/* hdl/oflow_bbox_writer.sv */
// PE side is never stalled; pairs beyond MAX_BBOX in a frame are dropped
// frame_num must hold from the first in_valid through frame_end
`timescale 1ns/1ps

module oflow_bbox_writer (
	input  logic                   clk,
	input  logic                   rst_n,
	// pe side
	input  logic                   in_valid,
	input  oflow_pkg::data_t       data_in_0,
	input  oflow_pkg::data_t       data_in_1,
	input  logic                   frame_end,
	input  oflow_pkg::frame_num_t  frame_num,
	// memory write port
	output logic                   wr_en,
	output oflow_pkg::addr_t       wr_addr,
	output oflow_pkg::data_t       wr_data_0,
	output oflow_pkg::data_t       wr_data_1,
	// frame commit to the slot table
	output logic                   commit_valid,
	output oflow_pkg::slot_t       commit_slot,
	output oflow_pkg::frame_num_t  commit_tag,
	output oflow_pkg::bbox_cnt_t   commit_count,
	output logic                   bbox_overflow
);

	import oflow_pkg::*;

	// running bbox count of the open frame
	bbox_cnt_t bbox_cnt;
	logic      accept;
	logic      drop;

	// room left in the slot
	assign accept = in_valid && (bbox_cnt < bbox_cnt_t'(MAX_BBOX));
	// slot full, pair is lost
	assign drop = in_valid && !accept;

	// --------------------------------------------------
	// control
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bbox_cnt      <= '0;
			wr_en         <= 1'b0;
			commit_valid  <= 1'b0;
			bbox_overflow <= 1'b0;
		end else begin
			wr_en        <= accept;
			commit_valid <= frame_end;
			// frame_end closes the frame, a pair in the same cycle still counts
			if (frame_end)
				bbox_cnt <= '0;
			else if (accept)
				bbox_cnt <= bbox_cnt + 1'b1;
			// sticky until the commit of the frame is out
			bbox_overflow <= (bbox_overflow && !commit_valid) || drop;
		end
	end

	// --------------------------------------------------
	// payload
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (accept) begin
			// offset is the pair's index in the frame
			wr_addr   <= {slot_t'(frame_num), offset_t'(bbox_cnt)};
			wr_data_0 <= data_in_0;
			wr_data_1 <= data_in_1;
		end
		if (frame_end) begin
			commit_slot  <= slot_t'(frame_num);
			commit_tag   <= frame_num;
			// include the pair accepted on the frame_end cycle
			commit_count <= accept ? bbox_cnt + 1'b1 : bbox_cnt;
		end
	end

endmodule

/* mem_buffer/oflow_history_mem.sv */
// one write port, one registered read port; contents undefined after reset
// a read of the address being written returns the old word
`timescale 1ns/1ps

module oflow_history_mem (
	input  logic               clk,
	// write side, from the writer
	input  logic               wr_en,
	input  oflow_pkg::addr_t   wr_addr,
	input  oflow_pkg::data_t   wr_data_0,
	input  oflow_pkg::data_t   wr_data_1,
	// read side, from the reader
	input  logic               rd_en,
	input  oflow_pkg::addr_t   rd_addr,
	output oflow_pkg::data_t   rd_data_0,
	output oflow_pkg::data_t   rd_data_1
);

	import oflow_pkg::*;

	// bank 0 holds the first word of each pair, bank 1 the second
	data_t bank_0 [MEM_DEPTH];
	data_t bank_1 [MEM_DEPTH];

	// --------------------------------------------------
	// write port
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en) begin
			bank_0[wr_addr] <= wr_data_0;
			bank_1[wr_addr] <= wr_data_1;
		end
	end

	// --------------------------------------------------
	// read port
	// --------------------------------------------------
	// data valid the cycle after rd_en, held otherwise
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_data_0 <= bank_0[rd_addr];
			rd_data_1 <= bank_1[rd_addr];
		end
	end

endmodule

/* mem_buffer/oflow_history_reader.sv */
// start_read only while idle; frame_num must hold for the whole walk
// one credit per consumed pair, at most CREDIT_MAX pairs outstanding
`timescale 1ns/1ps

module oflow_history_reader (
	input  logic                   clk,
	input  logic                   rst_n,
	// control
	input  logic                   start_read,
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	// slot table lookup
	output oflow_pkg::slot_t       tbl_slot,
	input  oflow_pkg::frame_num_t  tbl_tag,
	input  oflow_pkg::bbox_cnt_t   tbl_count,
	input  logic                   tbl_valid,
	// memory read port
	output logic                   rd_en,
	output oflow_pkg::addr_t       rd_addr,
	input  oflow_pkg::data_t       rd_data_0,
	input  oflow_pkg::data_t       rd_data_1,
	// output stream to the similarity stage
	output logic                   out_valid,
	output oflow_pkg::data_t       data_out_0,
	output oflow_pkg::data_t       data_out_1,
	output oflow_pkg::hist_cnt_t   out_frame_age,
	output logic                   out_last,
	input  logic                   out_credit,
	output logic                   done_read
);

	import oflow_pkg::*;

	rd_state_t   state;
	// values latched at start
	frame_num_t  cur_frame;
	hist_cnt_t   hist_num;
	// age under scan or being read
	hist_cnt_t   age;
	offset_t     offset;
	// bit k set = frame of age k still to read
	logic [HIST_SLOTS-1:0] frame_mask;
	logic        scan_done;
	credit_cnt_t credit_cnt;

	frame_num_t  age_tag;
	logic        frame_ok;
	logic        issue;
	logic        frame_end_rd;
	logic        rd_last;

	// youngest age left in a mask, bit 0 is never set
	function automatic hist_cnt_t lowest_age(input logic [HIST_SLOTS-1:0] m);
		hist_cnt_t a;
		a = '0;
		for (int i = HIST_SLOTS - 1; i >= 1; i--) begin
			if (m[i])
				a = hist_cnt_t'(i);
		end
		return a;
	endfunction

	// --------------------------------------------------
	// table lookup and qualify
	// --------------------------------------------------
	assign age_tag  = cur_frame - frame_num_t'(age);
	assign tbl_slot = slot_t'(age_tag);
	// frame exists, was not overwritten by a newer one, and holds data
	assign frame_ok = (cur_frame >= frame_num_t'(age)) && tbl_valid &&
		(tbl_tag == age_tag) && (tbl_count != '0);

	// reads only go out against a credit
	assign issue        = (state == RD_ISSUE) && (credit_cnt != '0);
	assign frame_end_rd = ({1'b0, offset} == tbl_count - 1'b1);
	// last pair of the oldest qualifying frame
	assign rd_last      = frame_end_rd && (frame_mask == '0);

	assign rd_en   = issue;
	assign rd_addr = {tbl_slot, offset};

	// --------------------------------------------------
	// walk fsm
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= RD_IDLE;
			cur_frame  <= '0;
			hist_num   <= '0;
			age        <= '0;
			offset     <= '0;
			frame_mask <= '0;
			scan_done  <= 1'b0;
			done_read  <= 1'b0;
		end else begin
			done_read <= 1'b0;
			case (state)
				RD_IDLE: begin
					if (start_read) begin
						cur_frame  <= frame_num;
						hist_num   <= num_of_history_frames;
						age        <= hist_cnt_t'(1);
						frame_mask <= '0;
						// zero history skips the scan
						scan_done  <= (num_of_history_frames == '0);
						state      <= RD_SELECT;
					end
				end
				RD_SELECT: begin
					if (scan_done) begin
						if (frame_mask == '0) begin
							// empty walk
							done_read <= 1'b1;
							state     <= RD_IDLE;
						end else begin
							age                          <= lowest_age(frame_mask);
							frame_mask[lowest_age(frame_mask)] <= 1'b0;
							offset                       <= '0;
							state                        <= RD_ISSUE;
						end
					end else begin
						// one age per cycle
						frame_mask[age] <= frame_ok;
						if (age == hist_num)
							scan_done <= 1'b1;
						else
							age <= age + 1'b1;
					end
				end
				RD_ISSUE: begin
					if (issue) begin
						if (!frame_end_rd) begin
							offset <= offset + 1'b1;
						end else if (frame_mask == '0) begin
							state <= RD_DRAIN;
						end else begin
							// next older frame
							age                          <= lowest_age(frame_mask);
							frame_mask[lowest_age(frame_mask)] <= 1'b0;
							offset                       <= '0;
						end
					end
				end
				RD_DRAIN: begin
					// last pair is on the output this cycle
					if (out_valid && out_last) begin
						done_read <= 1'b1;
						state     <= RD_IDLE;
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// credits
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			credit_cnt <= credit_cnt_t'(CREDIT_MAX);
		else if (issue && !out_credit)
			credit_cnt <= credit_cnt - 1'b1;
		else if (!issue && out_credit && credit_cnt != credit_cnt_t'(CREDIT_MAX))
			credit_cnt <= credit_cnt + 1'b1;
	end

	// --------------------------------------------------
	// output stage, aligned with the memory read data
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= issue;
			out_last  <= issue && rd_last;
		end
	end

	// age rides along with each read
	always_ff @(posedge clk) begin
		if (issue)
			out_frame_age <= age;
	end

	assign data_out_0 = rd_data_0;
	assign data_out_1 = rd_data_1;

endmodule

/* mem_buffer/oflow_mem_buffer_wrapper.sv */
// table entries are valid only after their commit; tags hold the full frame number
// start_read must come after the done_write of the newest frame
`timescale 1ns/1ps

module oflow_mem_buffer_wrapper (
	input  logic                   clk,
	input  logic                   rst_n,
	// writer side
	input  logic                   wr_en,
	input  oflow_pkg::addr_t       wr_addr,
	input  oflow_pkg::data_t       wr_data_0,
	input  oflow_pkg::data_t       wr_data_1,
	input  logic                   commit_valid,
	input  oflow_pkg::slot_t       commit_slot,
	input  oflow_pkg::frame_num_t  commit_tag,
	input  oflow_pkg::bbox_cnt_t   commit_count,
	// read control
	input  logic                   start_read,
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	input  logic                   out_credit,
	// output stream
	output logic                   out_valid,
	output oflow_pkg::data_t       data_out_0,
	output oflow_pkg::data_t       data_out_1,
	output oflow_pkg::hist_cnt_t   out_frame_age,
	output logic                   out_last,
	output logic                   done_read
);

	import oflow_pkg::*;

	// --------------------------------------------------
	// per slot frame table
	// --------------------------------------------------
	frame_num_t            tag_tbl   [HIST_SLOTS];
	bbox_cnt_t             count_tbl [HIST_SLOTS];
	logic [HIST_SLOTS-1:0] valid_tbl;

	// reader lookup
	slot_t      tbl_slot;
	frame_num_t tbl_tag;
	bbox_cnt_t  tbl_count;
	logic       tbl_valid;

	// memory read port
	logic  rd_en;
	addr_t rd_addr;
	data_t rd_data_0;
	data_t rd_data_1;

	// commit lands on the same edge as the frame's last pair
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			valid_tbl <= '0;
		else if (commit_valid)
			valid_tbl[commit_slot] <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (commit_valid) begin
			tag_tbl[commit_slot]   <= commit_tag;
			count_tbl[commit_slot] <= commit_count;
		end
	end

	assign tbl_tag   = tag_tbl[tbl_slot];
	assign tbl_count = count_tbl[tbl_slot];
	assign tbl_valid = valid_tbl[tbl_slot];

	// --------------------------------------------------
	// storage and reader
	// --------------------------------------------------
	oflow_history_mem u_mem (
		.clk       (clk),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data_0 (wr_data_0),
		.wr_data_1 (wr_data_1),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.rd_data_0 (rd_data_0),
		.rd_data_1 (rd_data_1)
	);

	oflow_history_reader u_reader (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.start_read            (start_read),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.tbl_slot              (tbl_slot),
		.tbl_tag               (tbl_tag),
		.tbl_count             (tbl_count),
		.tbl_valid             (tbl_valid),
		.rd_en                 (rd_en),
		.rd_addr               (rd_addr),
		.rd_data_0             (rd_data_0),
		.rd_data_1             (rd_data_1),
		.out_valid             (out_valid),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1),
		.out_frame_age         (out_frame_age),
		.out_last              (out_last),
		.out_credit            (out_credit),
		.done_read             (done_read)
	);

endmodule

/* hdl/oflow_mem_buffer_top.sv */
// history buffer top; frame_num must be stable during a frame and a read
// done_write is high for one cycle per committed frame
`timescale 1ns/1ps

module oflow_mem_buffer_top (
	input  logic                   clk,
	input  logic                   rst_n,
	// pe inputs
	input  logic                   in_valid,
	input  oflow_pkg::data_t       data_in_0,
	input  oflow_pkg::data_t       data_in_1,
	input  logic                   frame_end,
	// global frame state
	input  oflow_pkg::frame_num_t  frame_num,
	input  oflow_pkg::hist_cnt_t   num_of_history_frames,
	// core control
	input  logic                   start_read,
	output logic                   done_read,
	output logic                   done_write,
	// stream to the similarity metric
	output logic                   out_valid,
	output oflow_pkg::data_t       data_out_0,
	output oflow_pkg::data_t       data_out_1,
	output oflow_pkg::hist_cnt_t   out_frame_age,
	output logic                   out_last,
	input  logic                   out_credit,
	// status
	output logic                   bbox_overflow
);

	import oflow_pkg::*;

	// --------------------------------------------------
	// writer to buffer
	// --------------------------------------------------
	logic       wr_en;
	addr_t      wr_addr;
	data_t      wr_data_0;
	data_t      wr_data_1;
	logic       commit_valid;
	slot_t      commit_slot;
	frame_num_t commit_tag;
	bbox_cnt_t  commit_count;

	// frame is readable once committed
	assign done_write = commit_valid;

	oflow_bbox_writer u_writer (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.data_in_0     (data_in_0),
		.data_in_1     (data_in_1),
		.frame_end     (frame_end),
		.frame_num     (frame_num),
		.wr_en         (wr_en),
		.wr_addr       (wr_addr),
		.wr_data_0     (wr_data_0),
		.wr_data_1     (wr_data_1),
		.commit_valid  (commit_valid),
		.commit_slot   (commit_slot),
		.commit_tag    (commit_tag),
		.commit_count  (commit_count),
		.bbox_overflow (bbox_overflow)
	);

	oflow_mem_buffer_wrapper u_buffer (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.wr_en                 (wr_en),
		.wr_addr               (wr_addr),
		.wr_data_0             (wr_data_0),
		.wr_data_1             (wr_data_1),
		.commit_valid          (commit_valid),
		.commit_slot           (commit_slot),
		.commit_tag            (commit_tag),
		.commit_count          (commit_count),
		.start_read            (start_read),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.out_credit            (out_credit),
		.out_valid             (out_valid),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1),
		.out_frame_age         (out_frame_age),
		.out_last              (out_last),
		.done_read             (done_read)
	);

endmodule

/* verification/oflow_mem_buffer_properties.sv */
// credit and done rules of the history reader
// assumes credits are only returned for pairs already emitted
`timescale 1ns/1ps

module oflow_mem_buffer_properties (
	input logic clk,
	input logic rst_n,
	input logic rd_en,
	input logic out_valid,
	input logic out_last,
	input logic out_credit,
	input logic done_read
);

	import oflow_pkg::*;

	// pairs emitted but not yet paid back
	int unpaid;
	// a pair went out since the previous done_read
	logic emitted;
	// count of failed assertions
	int failures = 0;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			unpaid <= 0;
		else
			unpaid <= unpaid + int'(out_valid) - int'(out_credit);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			emitted <= 1'b0;
		else if (done_read)
			emitted <= 1'b0;
		else if (out_valid)
			emitted <= 1'b1;
	end

	// --------------------------------------------------
	// credit rules
	// --------------------------------------------------
	// the pair on the output counts too
	a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> unpaid < CREDIT_MAX)
		else begin
			$error("more than %0d pairs outstanding", CREDIT_MAX);
			failures++;
		end

	// a read needs a free credit by this checker's own count
	a_no_read_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
		rd_en |-> unpaid + int'(out_valid) < CREDIT_MAX)
		else begin
			$error("read issued with no credit left");
			failures++;
		end

	// --------------------------------------------------
	// done rules
	// --------------------------------------------------
	a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		done_read |=> !done_read)
		else begin
			$error("done_read longer than one cycle");
			failures++;
		end

	// after the last pair, or on a walk that emitted nothing
	a_done_cause: assert property (@(posedge clk) disable iff (!rst_n)
		done_read |-> $past(out_valid && out_last) || !emitted)
		else begin
			$error("done_read without a last pair or an empty walk");
			failures++;
		end

endmodule

/* verification/oflow_mem_buffer_tb.sv */
// table driven test of the history buffer; a read uses the row's frame number as current frame
// credits come back one per emitted pair after random gaps of 0-5 cycles
`timescale 1ns/1ps

module oflow_mem_buffer_tb;

	import oflow_pkg::*;

	localparam int ROWS = 13;
	// 40 cycles per row plus slack
	localparam int CYCLE_LIMIT = 40 * ROWS + 200;

	logic       clk;
	logic       rst_n;
	logic       in_valid;
	data_t      data_in_0;
	data_t      data_in_1;
	logic       frame_end;
	frame_num_t frame_num;
	hist_cnt_t  num_of_history_frames;
	logic       start_read;
	logic       done_read;
	logic       done_write;
	logic       out_valid;
	data_t      data_out_0;
	data_t      data_out_1;
	hist_cnt_t  out_frame_age;
	logic       out_last;
	logic       out_credit;
	logic       bbox_overflow;

	// --------------------------------------------------
	// stimulus table, one row per frame
	// --------------------------------------------------
	// frame number, bboxes sent, read after commit, history depth, pairs expected back
	int row_frame [ROWS] = '{0, 1, 2, 3, 4, 5, 7, 12, 13, 20, 21, 22, 23};
	int row_count [ROWS] = '{3, 4, 0, 5, 18, 2, 3, 2, 1, 2, 6, 4, 3};
	bit row_read  [ROWS] = '{1, 0, 0, 1, 0, 1, 1, 0, 1, 1, 0, 1, 1};
	int row_hist  [ROWS] = '{3, 0, 0, 3, 0, 2, 3, 0, 7, 4, 0, 2, 1};
	int row_pairs [ROWS] = '{0, 0, 0, 7, 0, 21, 18, 0, 5, 0, 0, 8, 4};

	// slot model of the ring
	int m_tag   [HIST_SLOTS];
	int m_count [HIST_SLOTS];
	bit m_valid [HIST_SLOTS];
	// expected stream of the read in progress
	hist_cnt_t exp_age [$];
	data_t     exp_d0 [$];
	data_t     exp_d1 [$];
	// output is legal only while set
	bit reading = 1'b0;

	oflow_mem_buffer_top dut (
		.clk                   (clk),
		.rst_n                 (rst_n),
		.in_valid              (in_valid),
		.data_in_0             (data_in_0),
		.data_in_1             (data_in_1),
		.frame_end             (frame_end),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.start_read            (start_read),
		.done_read             (done_read),
		.done_write            (done_write),
		.out_valid             (out_valid),
		.data_out_0            (data_out_0),
		.data_out_1            (data_out_1),
		.out_frame_age         (out_frame_age),
		.out_last              (out_last),
		.out_credit            (out_credit),
		.bbox_overflow         (bbox_overflow)
	);

	bind oflow_history_reader oflow_mem_buffer_properties u_props (
		.clk        (clk),
		.rst_n      (rst_n),
		.rd_en      (rd_en),
		.out_valid  (out_valid),
		.out_last   (out_last),
		.out_credit (out_credit),
		.done_read  (done_read)
	);

	initial begin : clock_gen
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		assert (actual === expected) else
			stop_on_error($sformatf("error: %s = 0x%0h, expected 0x%0h", name, actual, expected));
	endtask

	task automatic compare_word(input string name, input data_t actual, input data_t expected);
		assert (actual === expected) else
			stop_on_error($sformatf("error: %s = 0x%08h, expected 0x%08h", name, actual, expected));
	endtask

	// pair i of frame f, each word depends on both
	function automatic data_t pair_word(input int f, input int i, input bit second);
		if (second)
			return {8'h5e, 8'(i), 8'(f), 8'hc3 ^ 8'(f)};
		return {8'ha7, 8'(f), 8'(i) ^ 8'h3c, 8'(f + i)};
	endfunction

	// one frame of n pairs, frame_end rides on the last pair
	task automatic write_frame(input int f, input int n);
		int beats;
		int s;
		beats = (n > 0) ? n : 1;
		for (int i = 0; i < beats; i++) begin
			@(posedge clk);
			frame_num <= frame_num_t'(f);
			in_valid  <= (n > 0);
			data_in_0 <= pair_word(f, i, 1'b0);
			data_in_1 <= pair_word(f, i, 1'b1);
			frame_end <= (i == beats - 1);
		end
		@(posedge clk);
		in_valid  <= 1'b0;
		frame_end <= 1'b0;
		// done_write one cycle after frame_end, overflow still held
		@(posedge clk);
		check_flag("done_write", done_write, 1'b1);
		check_flag("bbox_overflow", bbox_overflow, n > MAX_BBOX);
		s = f % HIST_SLOTS;
		m_tag[s]   = f;
		m_count[s] = (n > MAX_BBOX) ? MAX_BBOX : n;
		m_valid[s] = 1'b1;
		@(posedge clk);
		check_flag("done_write", done_write, 1'b0);
		check_flag("bbox_overflow", bbox_overflow, 1'b0);
	endtask

	task automatic read_history(input int f, input int h, input int pairs);
		int  s;
		int  got;
		bit  done;
		bit  prev_last;
		exp_age.delete();
		exp_d0.delete();
		exp_d1.delete();
		// newest age first, offsets ascending
		for (int k = 1; k <= h; k++) begin
			if (f >= k) begin
				s = (f - k) % HIST_SLOTS;
				if (m_valid[s] && m_tag[s] == f - k && m_count[s] != 0) begin
					for (int i = 0; i < m_count[s]; i++) begin
						exp_age.push_back(hist_cnt_t'(k));
						exp_d0.push_back(pair_word(f - k, i, 1'b0));
						exp_d1.push_back(pair_word(f - k, i, 1'b1));
					end
				end
			end
		end
		assert (exp_age.size() == pairs) else
			stop_on_error($sformatf("frame model gives %0d pairs for frame %0d, table expects %0d",
				exp_age.size(), f, pairs));
		reading = 1'b1;
		num_of_history_frames <= hist_cnt_t'(h);
		start_read <= 1'b1;
		@(posedge clk);
		start_read <= 1'b0;
		got = 0;
		done = 1'b0;
		prev_last = 1'b0;
		while (!done) begin
			@(posedge clk);
			if (done_read) begin
				assert (got == exp_age.size() && (got == 0 || prev_last)) else
					stop_on_error("done_read came before the last expected pair");
				done = 1'b1;
			end
			prev_last = out_valid && out_last;
			if (out_valid) begin
				assert (got < exp_age.size()) else
					stop_on_error("an output pair arrived beyond the expected stream");
				compare_word("data_out_0", data_out_0, exp_d0[got]);
				compare_word("data_out_1", data_out_1, exp_d1[got]);
				compare_word("out_frame_age", data_t'(out_frame_age), data_t'(exp_age[got]));
				check_flag("out_last", out_last, got == exp_age.size() - 1);
				got++;
			end
		end
		@(posedge clk);
		reading = 1'b0;
	endtask

	// --------------------------------------------------
	// credit return, one per emitted pair
	// --------------------------------------------------
	initial begin : credit_returner
		int owed;
		int gap;
		void'($urandom(95));
		owed = 0;
		gap = 0;
		forever begin
			@(posedge clk);
			if (out_valid)
				owed++;
			if (owed > 0 && gap == 0) begin
				out_credit <= 1'b1;
				owed--;
				gap = $urandom_range(5, 0);
			end else begin
				out_credit <= 1'b0;
				if (gap > 0)
					gap--;
			end
		end
	end

	// run limit, stray output and the reader assertions
	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > CYCLE_LIMIT)
				stop_on_error($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
			assert (reading || (!out_valid && !done_read)) else
				stop_on_error("output or done_read appeared with no read in progress");
			assert (dut.u_buffer.u_reader.u_props.failures == 0) else
				stop_on_error("a credit or done_read assertion on the reader failed");
		end
	end

	initial begin : main
		rst_n = 1'b0;
		in_valid = 1'b0;
		data_in_0 = '0;
		data_in_1 = '0;
		frame_end = 1'b0;
		frame_num = '0;
		num_of_history_frames = '0;
		start_read = 1'b0;
		out_credit = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_flag("out_valid", out_valid, 1'b0);
		check_flag("done_read", done_read, 1'b0);
		check_flag("done_write", done_write, 1'b0);
		check_flag("bbox_overflow", bbox_overflow, 1'b0);
		compare_word("credit_cnt", data_t'(dut.u_buffer.u_reader.credit_cnt), CREDIT_MAX);
		for (int r = 0; r < ROWS; r++) begin
			write_frame(row_frame[r], row_count[r]);
			if (row_read[r])
				read_history(row_frame[r], row_hist[r], row_pairs[r]);
		end
		repeat (4) @(posedge clk);
		$display("No errors");
		$finish;
	end

endmodule

/* src.f */
common/oflow_pkg.sv
hdl/oflow_bbox_writer.sv
mem_buffer/oflow_history_mem.sv
mem_buffer/oflow_history_reader.sv
mem_buffer/oflow_mem_buffer_wrapper.sv
hdl/oflow_mem_buffer_top.sv
verification/oflow_mem_buffer_properties.sv
verification/oflow_mem_buffer_tb.sv

/* Makefile */
# Verilator build of the history buffer testbench

VERILATOR  ?= verilator
FILELIST   := src.f
TB_TOP     := oflow_mem_buffer_tb
RTL_TOP    := oflow_mem_buffer_top
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
FAIL_MSG   := Errors found

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation failed"; \
		exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
